/* logic/mvu_cfg.svh */
// Configuration macros of the matrix-vector unit
// Widths, memory depths and lane count
// Bus register offsets and memory regions
// Read latency and product pipeline depth
`ifndef MVU_CFG_SVH
`define MVU_CFG_SVH

`define MVU_LANES       4       // Vector lanes per word
`define MVU_ELEM_W      8       // Input and weight element width
`define MVU_WORD_W      32      // Memory and bus word
`define MVU_ACC_W       32      // Accumulator and result width
`define MVU_WADDR_W     4       // 16 weight rows
`define MVU_DADDR_W     5       // 32 data words
`define MVU_PREC_W      3       // Precision minus 1 so 1 to 8 bits
`define MVU_ROWS_W      4       // Rows minus 1 so 1 to 16 rows
`define MVU_ADR_W       8       // Byte address on the bus

`define MVU_MEMRD_LAT   1       // Registered memory reads
`define MVU_VVP_STAGES  2       // Lane sum then shift-accumulate

`define MVU_REG_CONTROL 8'h00   // Bit 0 d_signed and bit 1 w_signed, bits 10:8 precision minus 1
`define MVU_REG_BASES   8'h04   // Weight base 3:0, input base 12:8, output base 20:16
`define MVU_REG_ROWS    8'h08   // Rows minus 1 in bits 3:0
`define MVU_REG_STATUS  8'h0C   // Reads irq done busy in 2:0, bit 0 starts and bit 1 clears

`define MVU_WMEM_BASE   8'h40   // Weight memory region
`define MVU_DMEM_BASE   8'h80   // Data memory region

`endif

/* logic/mvu_pkg.sv */
// Shared types of the matrix-vector unit
// Wishbone request and response
// Host memory write, job configuration and one pipeline step
`include "mvu_cfg.svh"

package mvu_pkg;

    typedef struct packed {
        logic                       cyc;
        logic                       stb;
        logic                       we;
        logic [`MVU_ADR_W-1:0]      adr;        // Byte address
        logic [`MVU_WORD_W-1:0]     dat;        // Write data
    } wb_req_t;

    typedef struct packed {
        logic                       ack;
        logic [`MVU_WORD_W-1:0]     dat;        // Read data, valid with ack
    } wb_rsp_t;

    typedef struct packed {
        logic                       en;
        logic [`MVU_DADDR_W-1:0]    addr;       // Weight memory takes the low bits
        logic [`MVU_WORD_W-1:0]     word;
    } mem_wr_t;

    typedef struct packed {
        logic                       d_signed;
        logic                       w_signed;
        logic [`MVU_PREC_W-1:0]     prec_m1;    // Input precision minus 1
        logic [`MVU_ROWS_W-1:0]     rows_m1;    // Weight rows minus 1
        logic [`MVU_WADDR_W-1:0]    w_base;
        logic [`MVU_DADDR_W-1:0]    i_base;
        logic [`MVU_DADDR_W-1:0]    o_base;
    } job_cfg_t;

    typedef struct packed {
        logic                       valid;
        logic [`MVU_PREC_W-1:0]     bit_idx;    // Input bit in each lane byte
        logic                       first;      // MSB of the row
        logic                       last;       // LSB of the row
        logic [`MVU_DADDR_W-1:0]    o_addr;     // Result address of the row
    } vvp_step_t;

endpackage

/* logic/mvu_ctrl.sv */
// Wishbone classic slave with a single-cycle ack
// CONTROL, BASES and ROWS registers and the busy, done and irq flags
// Address decode for registers, weight memory and data memory
// Job state machine with idle, running and done
`timescale 1ns/10ps
`include "mvu_cfg.svh"

module mvu_ctrl (
    input  logic                        clk,
    input  logic                        arst_n,
    input  mvu_pkg::wb_req_t            bus,
    output mvu_pkg::wb_rsp_t            bus_rsp,
    output mvu_pkg::mem_wr_t            host_wmem,
    output mvu_pkg::mem_wr_t            host_dmem,
    output logic [`MVU_DADDR_W-1:0]     host_rd_addr,
    input  logic [`MVU_WORD_W-1:0]      wmem_rd_word,
    input  logic [`MVU_WORD_W-1:0]      dmem_rd_word,
    output mvu_pkg::job_cfg_t           cfg,
    output logic                        start,
    input  logic                        row_done,
    output logic                        irq
);

    typedef enum logic [1:0] {S_IDLE, S_RUN, S_DONE} state_t;

    state_t                     state_q;
    logic                       ack_q;
    logic [1:0]                 rsel_q;         // Dmem and wmem select of the acked access
    logic [`MVU_WORD_W-1:0]     reg_rd_q;       // Register read data
    logic [`MVU_WORD_W-1:0]     control_q;
    logic [`MVU_WORD_W-1:0]     bases_q;
    logic [`MVU_WORD_W-1:0]     rows_q;
    logic [`MVU_ROWS_W-1:0]     row_cnt_q;      // Rows written back so far
    logic                       irq_q;
    logic                       start_q;
    logic                       req;
    logic                       is_wmem;
    logic                       is_dmem;
    logic                       wr_status;
    logic                       launch;
    logic                       clear;
    logic                       finish;
    logic                       busy;
    logic                       done;

    assign req       = bus.cyc & bus.stb & ~ack_q;             // Access cycle, ack follows
    assign is_dmem   = (bus.adr >= `MVU_DMEM_BASE);
    assign is_wmem   = ~is_dmem & (bus.adr >= `MVU_WMEM_BASE);
    assign busy      = (state_q == S_RUN);
    assign done      = (state_q == S_DONE);
    assign wr_status = req & bus.we & (bus.adr == `MVU_REG_STATUS);
    assign launch    = wr_status & bus.dat[0] & ~busy & ~start_q;  // Dropped while running
    assign clear     = wr_status & bus.dat[1];
    assign finish    = busy & row_done & (row_cnt_q == cfg.rows_m1);  // Last row written

    assign host_wmem.en   = req & bus.we & is_wmem;
    assign host_wmem.addr = bus.adr[`MVU_DADDR_W+1:2];
    assign host_wmem.word = bus.dat;
    assign host_dmem.en   = req & bus.we & is_dmem;
    assign host_dmem.addr = bus.adr[`MVU_DADDR_W+1:2];
    assign host_dmem.word = bus.dat;
    assign host_rd_addr   = bus.adr[`MVU_DADDR_W+1:2];         // Both memories read, mux on ack

    assign bus_rsp.ack = ack_q;
    assign bus_rsp.dat = rsel_q[1] ? dmem_rd_word : (rsel_q[0] ? wmem_rd_word : reg_rd_q);
    assign start       = start_q;
    assign irq         = irq_q;

    // Bus handshake and host registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q     <= 1'b0;
            control_q <= '0;
            bases_q   <= '0;
            rows_q    <= '0;
        end else begin
            ack_q <= req;                                      // One clock, never held
            if (req && bus.we) begin
                case (bus.adr)
                    `MVU_REG_CONTROL: control_q <= bus.dat;
                    `MVU_REG_BASES:   bases_q   <= bus.dat;
                    `MVU_REG_ROWS:    rows_q    <= bus.dat;
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            rsel_q <= {is_dmem, is_wmem};
            case (bus.adr)
                `MVU_REG_CONTROL: reg_rd_q <= control_q;
                `MVU_REG_BASES:   reg_rd_q <= bases_q;
                `MVU_REG_ROWS:    reg_rd_q <= rows_q;
                `MVU_REG_STATUS:  reg_rd_q <= {{(`MVU_WORD_W-3){1'b0}}, irq_q, done, busy};
                default:          reg_rd_q <= '0;
            endcase
        end
        if (launch) begin                                      // Job values frozen at start
            cfg.d_signed <= control_q[0];
            cfg.w_signed <= control_q[1];
            cfg.prec_m1  <= control_q[8 +: `MVU_PREC_W];
            cfg.rows_m1  <= rows_q[`MVU_ROWS_W-1:0];
            cfg.w_base   <= bases_q[0 +: `MVU_WADDR_W];
            cfg.i_base   <= bases_q[8 +: `MVU_DADDR_W];
            cfg.o_base   <= bases_q[16 +: `MVU_DADDR_W];
        end
    end

    // Job FSM
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q   <= S_IDLE;
            start_q   <= 1'b0;
            irq_q     <= 1'b0;
            row_cnt_q <= '0;
        end else begin
            start_q <= launch;
            if (start_q)
                row_cnt_q <= '0;
            else if (row_done)
                row_cnt_q <= row_cnt_q + 1'b1;
            case (state_q)
                S_RUN: if (finish) state_q <= S_DONE;          // busy falls as done rises
                default: begin
                    if (start_q)
                        state_q <= S_RUN;
                    else if (clear)
                        state_q <= S_IDLE;
                end
            endcase
            if (finish)
                irq_q <= 1'b1;                                 // Sticky until cleared
            else if (clear)
                irq_q <= 1'b0;
        end
    end

    a_ack_single: assert property (@(posedge clk) disable iff (!arst_n) ack_q |=> !ack_q)
        else $error("ack high in two consecutive clocks");
    a_start_idle: assert property (@(posedge clk) disable iff (!arst_n) start_q |-> !busy)
        else $error("start issued while busy");

endmodule

/* logic/mvu_agu.sv */
// Address generator of the matrix-vector unit
// Row counter and downward input bit counter
// Weight, input and output addresses with first and last bit flags
`timescale 1ns/10ps
`include "mvu_cfg.svh"

module mvu_agu (
    input  logic                        clk,
    input  logic                        arst_n,
    input  mvu_pkg::job_cfg_t           cfg,
    input  logic                        start,
    output logic [`MVU_DADDR_W-1:0]     in_addr,
    output logic [`MVU_WADDR_W-1:0]     w_addr,
    output mvu_pkg::vvp_step_t          step
);

    logic                       run_q;          // Issuing steps
    logic [`MVU_ROWS_W-1:0]     row_q;
    logic [`MVU_PREC_W-1:0]     bit_q;          // Counts down to the LSB
    logic                       row_end;
    logic                       job_end;

    assign row_end = (bit_q == '0);
    assign job_end = row_end & (row_q == cfg.rows_m1);

    assign in_addr      = cfg.i_base;                          // Read on the start cycle
    assign w_addr       = cfg.w_base + row_q;
    assign step.valid   = run_q;
    assign step.bit_idx = bit_q;
    assign step.first   = (bit_q == cfg.prec_m1);              // MSB issued first
    assign step.last    = row_end;
    assign step.o_addr  = cfg.o_base + `MVU_DADDR_W'(row_q);

    // One step per clock, rows back to back
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run_q <= 1'b0;
            row_q <= '0;
            bit_q <= '0;
        end else if (start) begin
            run_q <= 1'b1;
            row_q <= '0;
            bit_q <= cfg.prec_m1;
        end else if (run_q) begin
            if (row_end) begin
                bit_q <= cfg.prec_m1;                          // Next row starts at MSB
                row_q <= row_q + 1'b1;
                if (job_end)
                    run_q <= 1'b0;
            end else begin
                bit_q <= bit_q - 1'b1;
            end
        end
    end

    a_bit_range: assert property (@(posedge clk) disable iff (!arst_n)
        step.valid |-> (step.bit_idx <= cfg.prec_m1))
        else $error("bit index %0d above precision %0d", step.bit_idx, cfg.prec_m1);

endmodule

/* logic/mvu_mem.sv */
// Weight memory and data memory of the matrix-vector unit
// Each has a host port and a datapath port with registered reads
// Datapath result writes win over host writes to the same address
`timescale 1ns/10ps
`include "mvu_cfg.svh"

module mvu_mem (
    input  logic                        clk,
    input  mvu_pkg::mem_wr_t            host_wmem,
    input  mvu_pkg::mem_wr_t            host_dmem,
    input  logic [`MVU_DADDR_W-1:0]     host_rd_addr,
    output logic [`MVU_WORD_W-1:0]      wmem_rd_word,
    output logic [`MVU_WORD_W-1:0]      dmem_rd_word,
    input  logic [`MVU_WADDR_W-1:0]     w_addr,
    output logic [`MVU_WORD_W-1:0]      w_word,
    input  logic [`MVU_DADDR_W-1:0]     in_addr,
    output logic [`MVU_WORD_W-1:0]      in_word,
    input  mvu_pkg::mem_wr_t            res_wr
);

    logic [`MVU_WORD_W-1:0] wmem [2**`MVU_WADDR_W];            // One row of 4 weights per word
    logic [`MVU_WORD_W-1:0] dmem [2**`MVU_DADDR_W];            // Input vectors and results

    // Weight memory
    always_ff @(posedge clk) begin
        if (host_wmem.en)
            wmem[host_wmem.addr[`MVU_WADDR_W-1:0]] <= host_wmem.word;
        wmem_rd_word <= wmem[host_rd_addr[`MVU_WADDR_W-1:0]];
        w_word       <= wmem[w_addr];                          // Meets the delayed step
    end

    // Data memory
    always_ff @(posedge clk) begin
        if (host_dmem.en)
            dmem[host_dmem.addr] <= host_dmem.word;
        if (res_wr.en)
            dmem[res_wr.addr] <= res_wr.word;                  // Later write takes the address
        dmem_rd_word <= dmem[host_rd_addr];
        in_word      <= dmem[in_addr];
    end

endmodule

/* logic/mvu_vvp.sv */
// Bit-serial vector product of the matrix-vector unit
// Input vector capture and step delay to meet the weight word
// Lane products with signed weights and MSB negation
// Shift-accumulator with one result write per row
`timescale 1ns/10ps
`include "mvu_cfg.svh"

module mvu_vvp (
    input  logic                        clk,
    input  logic                        arst_n,
    input  mvu_pkg::job_cfg_t           cfg,
    input  logic                        start,
    input  logic [`MVU_WORD_W-1:0]      in_word,
    input  logic [`MVU_WORD_W-1:0]      w_word,
    input  mvu_pkg::vvp_step_t          step,
    output mvu_pkg::mem_wr_t            res_wr,
    output logic                        row_done
);

    import mvu_pkg::*;

    vvp_step_t [`MVU_MEMRD_LAT-1:0] dly_q;                     // Step waiting on the weight read
    vvp_step_t                      cur;                       // Step aligned to w_word
    vvp_step_t                      s1_q;                      // Step beside the lane sum
    logic                           start_q;
    logic                           seen_q;                    // A step arrived in this job
    logic [`MVU_WORD_W-1:0]         vec_q;                     // Input vector of the job
    logic [`MVU_ACC_W-1:0]          lane_sum;
    logic [`MVU_ACC_W-1:0]          sum_q;
    logic [`MVU_ACC_W-1:0]          acc_q;
    logic                           wr_q;
    logic [`MVU_DADDR_W-1:0]        wr_addr_q;

    assign cur = dly_q[`MVU_MEMRD_LAT-1];

    // Stage 1 input, sum of the selected lane weights
    always_comb begin
        logic [`MVU_ACC_W-1:0] prod;
        lane_sum = '0;
        for (int i = 0; i < `MVU_LANES; i++) begin
            prod = cfg.w_signed ? `MVU_ACC_W'(signed'(w_word[i*`MVU_ELEM_W +: `MVU_ELEM_W]))
                                : `MVU_ACC_W'(w_word[i*`MVU_ELEM_W +: `MVU_ELEM_W]);
            if (vec_q[i*`MVU_ELEM_W + cur.bit_idx])
                lane_sum = lane_sum + prod;
        end
        if (cur.first && cfg.d_signed)
            lane_sum = -lane_sum;                              // Input MSB carries negative weight
    end

    // Control pipeline
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dly_q   <= '0;
            s1_q    <= '0;
            start_q <= 1'b0;
            seen_q  <= 1'b0;
            wr_q    <= 1'b0;
        end else begin
            dly_q[0] <= step;
            for (int i = 1; i < `MVU_MEMRD_LAT; i++)
                dly_q[i] <= dly_q[i-1];
            s1_q    <= cur;
            start_q <= start;
            wr_q    <= s1_q.valid & s1_q.last;                 // Row complete after this update
            if (start)
                seen_q <= 1'b0;
            else if (step.valid)
                seen_q <= 1'b1;
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (start_q)
            vec_q <= in_word;                                  // Read issued on the start cycle
        sum_q <= lane_sum;
        if (s1_q.valid)
            acc_q <= s1_q.first ? sum_q : (acc_q << 1) + sum_q;
        wr_addr_q <= s1_q.o_addr;
    end

    assign res_wr.en   = wr_q;
    assign res_wr.addr = wr_addr_q;
    assign res_wr.word = acc_q;
    assign row_done    = wr_q;

    a_write_after_step: assert property (@(posedge clk) disable iff (!arst_n)
        (res_wr.en || row_done) |-> seen_q)
        else $error("result write with no step since start");

endmodule

/* logic/mvu_top.sv */
// Top level of the matrix-vector unit
// Wishbone controller, address generator, memories and vector product
`timescale 1ns/10ps
`include "mvu_cfg.svh"

module mvu_top (
    input  logic                clk,
    input  logic                arst_n,
    input  mvu_pkg::wb_req_t    bus,
    output mvu_pkg::wb_rsp_t    bus_rsp,
    output logic                irq
);

    import mvu_pkg::*;

    mem_wr_t                    host_wmem;
    mem_wr_t                    host_dmem;
    mem_wr_t                    res_wr;         // Row result into data memory
    job_cfg_t                   cfg;
    vvp_step_t                  step;
    logic                       start;
    logic                       row_done;
    logic [`MVU_DADDR_W-1:0]    host_rd_addr;
    logic [`MVU_DADDR_W-1:0]    in_addr;
    logic [`MVU_WADDR_W-1:0]    w_addr;
    logic [`MVU_WORD_W-1:0]     wmem_rd_word;
    logic [`MVU_WORD_W-1:0]     dmem_rd_word;
    logic [`MVU_WORD_W-1:0]     w_word;
    logic [`MVU_WORD_W-1:0]     in_word;

    mvu_ctrl u_ctrl (
        .clk, .arst_n, .bus, .bus_rsp,
        .host_wmem, .host_dmem, .host_rd_addr, .wmem_rd_word, .dmem_rd_word,
        .cfg, .start, .row_done, .irq
    );

    mvu_agu u_agu (
        .clk, .arst_n, .cfg, .start, .in_addr, .w_addr, .step
    );

    mvu_mem u_mem (
        .clk, .host_wmem, .host_dmem, .host_rd_addr, .wmem_rd_word, .dmem_rd_word,
        .w_addr, .w_word, .in_addr, .in_word, .res_wr
    );

    mvu_vvp u_vvp (
        .clk, .arst_n, .cfg, .start, .in_word, .w_word, .step, .res_wr, .row_done
    );

endmodule

/* test/mvu_tb_cases.svh */
// Directed cases of the matrix-vector unit testbench
// Flags, precision, row count, input word, weight rows and expected results
`ifndef MVU_TB_CASES_SVH
`define MVU_TB_CASES_SVH

localparam int N_TABLE = 9;                                // Directed cases below

typedef struct packed {
    logic               d_signed;
    logic               w_signed;
    logic [3:0]         prec;                              // Input bits, 1 to 8
    logic [4:0]         rows;                              // 1 to 3 rows here
    logic [31:0]        in_word;                           // Lane 0 in the low byte
    logic [2:0][31:0]   w;                                 // Weight word per row
    logic [2:0][31:0]   exp;                               // Result per row
} case_t;

case_t case_q[$];

task automatic add_case(input logic ds, input logic ws, input int prec, input int rows,
                        input logic [31:0] in_word, input logic [31:0] w0,
                        input logic [31:0] w1, input logic [31:0] w2,
                        input logic [31:0] e0, input logic [31:0] e1,
                        input logic [31:0] e2);
    case_t c;
    c.d_signed = ds;
    c.w_signed = ws;
    c.prec     = 4'(prec);
    c.rows     = 5'(rows);
    c.in_word  = in_word;
    c.w        = {w2, w1, w0};
    c.exp      = {e2, e1, e0};
    case_q.push_back(c);
endtask

task automatic fill_table;
    add_case(0, 0, 1, 1, 32'h01000101, 32'h04030201, 0, 0, 32'd7, 0, 0);   // Single bit
    add_case(0, 0, 4, 2, 32'h0F0A0503, 32'h01020304, 32'h10101010, 0,
             32'h0000003E, 32'h00000210, 0);
    add_case(0, 0, 8, 1, 32'hFF807F01, 32'hFFFFFFFF, 0, 0, 32'h0001FD01, 0, 0);
    add_case(1, 0, 8, 1, 32'hFFFFFFFF, 32'h04030201, 0, 0, 32'hFFFFFFF6, 0, 0); // All ones
    add_case(1, 0, 4, 1, 32'h0F0F0F0F, 32'h10203040, 0, 0, 32'hFFFFFF60, 0, 0);
    add_case(0, 1, 8, 1, 32'h01020304, 32'hFFFE807F, 0, 0, 32'h00000077, 0, 0);
    add_case(1, 1, 8, 1, 32'h80FF7F81, 32'h80808080, 0, 0, 32'h00004080, 0, 0);
    add_case(1, 1, 3, 3, 32'h07040301, 32'hFF02FD05, 32'h01010101, 32'h00000000,
             32'hFFFFFFF5, 32'hFFFFFFFF, 32'h00000000);          // Three rows
    add_case(0, 1, 2, 1, 32'h03020103, 32'hFFFFFFFF, 0, 0, 32'hFFFFFFF7, 0, 0);
endtask

`endif

/* test/mvu_tb.sv */
// Testbench of the matrix-vector unit
// Clock, reset and Wishbone bus tasks
// Register and memory readback, directed table, busy start and random jobs
// Reference dot product and watchdog
`timescale 1ns/10ps
`include "mvu_cfg.svh"

module mvu_tb;

    import mvu_pkg::*;

    `include "mvu_tb_cases.svh"

    localparam int N_RANDOM   = 12;
    localparam int WD_CYCLES  = (N_TABLE + N_RANDOM + 4) * (16 * 8 + 200);

    logic           clk;
    logic           arst_n;
    wb_req_t        bus;
    wb_rsp_t        bus_rsp;
    logic           irq;
    logic [31:0]    wrow [16];                             // Weight word per job row
    logic [31:0]    exp_res [16];                          // Expected result per row
    int             fail_count;

    mvu_top DUT (.clk, .arst_n, .bus, .bus_rsp, .irq);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                            // 100 ns period
    end

    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("Watchdog expired before the tests completed");
        $display("Test failed");
        $fatal(1, "watchdog");
    end

    task automatic report_failure(input string msg);
        fail_count++;
        $display("%s at %0t", msg, $time);
        $display("Test failed");
        $fatal(1, "check");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            fail_count++;
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("Test failed");
            $fatal(1, "value");
        end
    endtask

    // One Wishbone classic cycle with the request held until ack
    task automatic bus_access(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                              output logic [31:0] rdat);
        @(negedge clk);
        bus.cyc = 1'b1;
        bus.stb = 1'b1;
        bus.we  = we;
        bus.adr = adr;
        bus.dat = wdat;
        do @(negedge clk); while (bus_rsp.ack !== 1'b1);   // Ack one clock after the request
        rdat    = bus_rsp.dat;
        bus.cyc = 1'b0;
        bus.stb = 1'b0;
        bus.we  = 1'b0;
    endtask

    task automatic bus_write(input logic [7:0] adr, input logic [31:0] wdat);
        logic [31:0] unused;
        bus_access(1'b1, adr, wdat, unused);
    endtask

    task automatic bus_read(input logic [7:0] adr, output logic [31:0] rdat);
        bus_access(1'b0, adr, '0, rdat);
    endtask

    // Sum over lanes of weight times input with inputs cut to prec bits
    function automatic logic [31:0] dot_ref(input logic ds, input logic ws, input int prec,
                                            input logic [31:0] in_word,
                                            input logic [31:0] w_word);
        int acc;
        int x;
        int w;
        acc = 0;
        for (int i = 0; i < 4; i++) begin
            x = int'(in_word[i*8 +: 8]) & ((1 << prec) - 1);
            if (ds && x[prec-1])
                x = x - (1 << prec);                       // Two's complement of prec bits
            w = int'(w_word[i*8 +: 8]);
            if (ws && w >= 128)
                w = w - 256;
            acc = acc + x * w;
        end
        return 32'(acc);
    endfunction

    task automatic wait_done;
        logic [31:0] st;
        int          polls;
        st    = '0;
        polls = 0;
        while (st[1] !== 1'b1) begin
            bus_read(`MVU_REG_STATUS, st);
            polls++;
            assert (st == 32'h1 || st == 32'h6) else
                report_failure("STATUS shows neither a running nor a finished job");
            assert (polls < 400) else report_failure("Job did not finish");
        end
        check_value("irq", {31'b0, irq}, 32'h1);           // Rose with done
    endtask

    task automatic start_job(input logic ds, input logic ws, input int prec, input int rows,
                             input int wbase, input int ibase, input int obase,
                             input logic [31:0] in_word);
        for (int r = 0; r < rows; r++)
            bus_write(8'(`MVU_WMEM_BASE + 4 * ((wbase + r) % 16)), wrow[r]);
        bus_write(8'(`MVU_DMEM_BASE + 4 * ibase), in_word);
        bus_write(`MVU_REG_CONTROL, ((prec - 1) << 8) | (ws << 1) | ds);
        bus_write(`MVU_REG_BASES, (obase << 16) | (ibase << 8) | wbase);
        bus_write(`MVU_REG_ROWS, rows - 1);
        bus_write(`MVU_REG_STATUS, 32'h1);
    endtask

    task automatic finish_job(input int rows, input int obase);
        logic [31:0] rd;
        wait_done();
        for (int r = 0; r < rows; r++) begin
            bus_read(8'(`MVU_DMEM_BASE + 4 * (obase + r)), rd);
            check_value($sformatf("dmem[%0d]", obase + r), rd, exp_res[r]);
        end
        bus_write(`MVU_REG_STATUS, 32'h2);                 // Clear done and irq
        bus_read(`MVU_REG_STATUS, rd);
        check_value("STATUS", rd, 32'h0);
        check_value("irq", {31'b0, irq}, 32'h0);
    endtask

    initial begin
        logic [31:0] rd;
        logic [7:0]  a;
        logic        ds;
        logic        ws;
        int          prec;
        int          rows;
        int          obase;
        logic [31:0] in_word;
        case_t       c;
        fail_count = 0;
        void'($urandom(32'h4095_1689));
        bus    = '0;
        arst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        check_value("irq", {31'b0, irq}, 32'h0);
        bus_read(`MVU_REG_STATUS, rd);
        check_value("STATUS", rd, 32'h0);
        bus_write(`MVU_REG_CONTROL, 32'hA5A5_0703);
        bus_write(`MVU_REG_BASES, 32'h0012_0A05);
        bus_write(`MVU_REG_ROWS, 32'h0000_000C);
        bus_read(`MVU_REG_CONTROL, rd);
        check_value("CONTROL", rd, 32'hA5A5_0703);
        bus_read(`MVU_REG_BASES, rd);
        check_value("BASES", rd, 32'h0012_0A05);
        bus_read(`MVU_REG_ROWS, rd);
        check_value("ROWS", rd, 32'h0000_000C);
        for (int i = 0; i < 48; i++) begin                 // 16 weight then 32 data words
            a = (i < 16) ? 8'(`MVU_WMEM_BASE + 4 * i) : 8'(`MVU_DMEM_BASE + 4 * (i - 16));
            bus_write(a, {a, ~a, a ^ 8'h5A, a + 8'h33});
        end
        for (int i = 0; i < 48; i++) begin
            a = (i < 16) ? 8'(`MVU_WMEM_BASE + 4 * i) : 8'(`MVU_DMEM_BASE + 4 * (i - 16));
            bus_read(a, rd);
            check_value($sformatf("mem at %h", a), rd, {a, ~a, a ^ 8'h5A, a + 8'h33});
        end

        fill_table();
        foreach (case_q[k]) begin
            c = case_q[k];
            for (int r = 0; r < 3; r++) begin
                wrow[r]    = c.w[r];
                exp_res[r] = c.exp[r];
            end
            start_job(c.d_signed, c.w_signed, c.prec, c.rows, 2, 3, 20, c.in_word);
            finish_job(c.rows, 20);
        end

        // Second start while busy must be dropped
        in_word = $urandom;
        for (int r = 0; r < 16; r++) begin
            wrow[r]    = $urandom;
            exp_res[r] = dot_ref(1'b1, 1'b1, 8, in_word, wrow[r]);
        end
        start_job(1'b1, 1'b1, 8, 16, 5, 1, 16, in_word);
        bus_write(`MVU_REG_CONTROL, 32'h0);                // One unsigned bit if it were taken
        bus_write(`MVU_REG_ROWS, 32'h0);                   // One row instead of 16
        bus_write(`MVU_REG_STATUS, 32'h1);
        finish_job(16, 16);
        repeat (200) @(negedge clk);
        bus_read(`MVU_REG_STATUS, rd);
        check_value("STATUS after ignored start", rd, 32'h0);

        for (int n = 0; n < N_RANDOM; n++) begin
            ds      = 1'($urandom);
            ws      = 1'($urandom);
            prec    = 1 + $urandom % 8;
            rows    = 1 + $urandom % 16;
            obase   = 8 + $urandom % (25 - rows);          // Clear of the input words
            in_word = $urandom;
            for (int r = 0; r < rows; r++) begin
                wrow[r]    = $urandom;
                exp_res[r] = dot_ref(ds, ws, prec, in_word, wrow[r]);
            end
            start_job(ds, ws, prec, rows, $urandom % 16, $urandom % 8, obase, in_word);
            finish_job(rows, obase);
        end

        if (fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+logic
+incdir+test
logic/mvu_pkg.sv
logic/mvu_ctrl.sv
logic/mvu_agu.sv
logic/mvu_mem.sv
logic/mvu_vvp.sv
logic/mvu_top.sv
test/mvu_tb.sv

/* Bender.yml */
package:
  name: mvu

sources:
  - include_dirs:
      - logic
    files:
      - logic/mvu_pkg.sv
      - logic/mvu_ctrl.sv
      - logic/mvu_agu.sv
      - logic/mvu_mem.sv
      - logic/mvu_vvp.sv
      - logic/mvu_top.sv
  - target: test
    include_dirs:
      - logic
      - test
    files:
      - test/mvu_tb.sv
